//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_lsi_control
FILELIST = lsi_control.f
PASS_MSG = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- ctl_sequencer.sv
/*
 * State register and output registers of the sequencer. Takes the
 * request bundle of whichever phase decoder owns the current state.
 */
`timescale 1ns/10ps
`default_nettype none

module ctl_sequencer (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          ready,
    input  logic                          ierror,
    output lsi_control_pkg::ctl_state_t   state,
    output lsi_control_pkg::opnd_side_t   side,
    output logic                          bus_done,
    output logic                          bus_err,
    input  logic                          fd_owns, of_owns, ex_owns, tr_owns,
    input  lsi_control_pkg::ctl_state_t   fd_next_state, of_next_state,
    input  lsi_control_pkg::ctl_state_t   ex_next_state, tr_next_state,
    input  lsi_control_pkg::dp_cmd_t      fd_cmd, of_cmd, ex_cmd, tr_cmd,
    input  logic                          fd_rd_req, of_rd_req, ex_rd_req, tr_rd_req,
    input  logic                          fd_wr_req, of_wr_req, ex_wr_req, tr_wr_req,
    input  logic                          fd_byte_req, of_byte_req, ex_byte_req, tr_byte_req,
    input  logic                          fd_fetch_req, of_fetch_req, ex_fetch_req, tr_fetch_req,
    input  logic                          fd_side_chg, of_side_chg, ex_side_chg, tr_side_chg,
    input  lsi_control_pkg::opnd_side_t   fd_side_val, of_side_val, ex_side_val, tr_side_val,
    output lsi_control_pkg::dp_cmd_t      dp_cmd,
    output logic                          dati,
    output logic                          dato,
    output logic                          mbyte,
    output logic                          ifetch
);
    import lsi_control_pkg::*;

    logic [STATE_W-1:0] sel_next;
    dp_cmd_t            sel_cmd;
    logic               sel_rd, sel_wr, sel_byte, sel_fetch, sel_side_chg;
    opnd_side_t         sel_side_val;

    // response to the strobe registered last cycle
    assign bus_done = (dati | dato) & ready;
    assign bus_err  = ierror;

    // ==============================
    // owner select
    // ==============================
    // one owner per state; an unowned code falls back to BOOT_0
    assign sel_next = ({STATE_W{fd_owns}} & fd_next_state) | ({STATE_W{of_owns}} & of_next_state)
                    | ({STATE_W{ex_owns}} & ex_next_state) | ({STATE_W{tr_owns}} & tr_next_state);
    assign sel_cmd = ({DP_CMD_W{fd_owns}} & fd_cmd) | ({DP_CMD_W{of_owns}} & of_cmd)
                   | ({DP_CMD_W{ex_owns}} & ex_cmd) | ({DP_CMD_W{tr_owns}} & tr_cmd);
    assign sel_rd = (fd_owns & fd_rd_req) | (of_owns & of_rd_req)
                  | (ex_owns & ex_rd_req) | (tr_owns & tr_rd_req);
    assign sel_wr = (fd_owns & fd_wr_req) | (of_owns & of_wr_req)
                  | (ex_owns & ex_wr_req) | (tr_owns & tr_wr_req);
    assign sel_byte = (fd_owns & fd_byte_req) | (of_owns & of_byte_req)
                    | (ex_owns & ex_byte_req) | (tr_owns & tr_byte_req);
    assign sel_fetch = (fd_owns & fd_fetch_req) | (of_owns & of_fetch_req)
                     | (ex_owns & ex_fetch_req) | (tr_owns & tr_fetch_req);
    assign sel_side_chg = (fd_owns & fd_side_chg) | (of_owns & of_side_chg)
                        | (ex_owns & ex_side_chg) | (tr_owns & tr_side_chg);
    assign sel_side_val = (fd_owns & fd_side_val) | (of_owns & of_side_val)
                        | (ex_owns & ex_side_val) | (tr_owns & tr_side_val);

    // ==============================
    // registers
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= BOOT_0;
            side   <= SRC_OP;
            dp_cmd <= '0;
            dati   <= 1'b0;
            dato   <= 1'b0;
            mbyte  <= 1'b0;
            ifetch <= 1'b0;
        end else begin
            state  <= ctl_state_t'(sel_next);
            dp_cmd <= sel_cmd;
            dati   <= sel_rd;
            dato   <= sel_wr;
            ifetch <= sel_fetch;
            // byte flag sticks between accesses
            if (sel_rd | sel_wr)
                mbyte <= sel_byte;
            if (sel_side_chg)
                side <= sel_side_val;
        end
    end

endmodule

`default_nettype wire

//--- execute_writeback.sv
/*
 * Execute state operation table and the writeback of the result to a
 * register or to memory.
 */
`timescale 1ns/10ps
`default_nettype none

module execute_writeback (
    input  lsi_control_pkg::ctl_state_t   state,
    input  lsi_control_pkg::word_t        opcode,
    input  lsi_control_pkg::idc_op_t      idc_op,
    input  logic                          bus_done,
    input  logic                          bus_err,
    output logic                          owns,
    output lsi_control_pkg::ctl_state_t   next_state,
    output lsi_control_pkg::dp_cmd_t      cmd,
    output logic                          rd_req,
    output logic                          wr_req,
    output logic                          byte_req,
    output logic                          fetch_req,
    output logic                          side_chg,
    output lsi_control_pkg::opnd_side_t   side_val
);
    import lsi_control_pkg::*;

    logic sop_hit, dop_hit, alu_hit, no_wb, trap_hit;

    assign sop_hit  = idc_op[dclr] | idc_op[dcom] | idc_op[dinc] | idc_op[ddec]
                    | idc_op[dneg] | idc_op[dtst];
    assign dop_hit  = idc_op[dmov] | idc_op[dcmp] | idc_op[dbit] | idc_op[dbic]
                    | idc_op[dbis] | idc_op[dadd];
    assign alu_hit  = sop_hit | dop_hit;
    // flags only, nothing to write back
    assign no_wb    = idc_op[dtst] | idc_op[dcmp] | idc_op[dbit];
    assign trap_hit = idc_op[dbpt] | idc_op[diot] | idc_op[demt] | idc_op[dtrap]
                    | idc_op[dhalt];

    assign owns = state inside {EX_0, WB_0};

    always_comb begin
        cmd        = '0;
        next_state = state;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        byte_req   = 1'b0;
        fetch_req  = 1'b0;
        side_chg   = 1'b0;
        side_val   = DST_OP;
        case (state)
            EX_0: begin
                cmd[DSTALU1] = sop_hit;
                cmd[SRCALU1] = dop_hit;
                cmd[DSTALU2] = dop_hit & ~idc_op[dmov];
                cmd[ALUDSTB] = sop_hit | (dop_hit & ~no_wb & ~idc_op[dmov]);
                cmd[ALUDST]  = idc_op[dmov];
                cmd[ALUCC]   = alu_hit;
                cmd[CLR]     = idc_op[dclr];
                cmd[COM]     = idc_op[dcom];
                cmd[INC]     = idc_op[dinc];
                cmd[DEC]     = idc_op[ddec];
                cmd[NEG]     = idc_op[dneg];
                cmd[TST]     = idc_op[dtst];
                cmd[MOV]     = idc_op[dmov];
                cmd[CMP]     = idc_op[dcmp];
                cmd[BIT]     = idc_op[dbit];
                cmd[BIC]     = idc_op[dbic];
                cmd[BIS]     = idc_op[dbis];
                cmd[ADD]     = idc_op[dadd];
                cmd[BPT]     = idc_op[dbpt];
                cmd[IOT]     = idc_op[diot];
                cmd[EMT]     = idc_op[demt];
                cmd[SVC]     = idc_op[dtrap];
                // halt traps like a bus error, as on the VM1
                cmd[BUSERR]  = idc_op[dhalt];
                if (alu_hit)
                    next_state = no_wb ? FS_IF0 : WB_0;
                else if (trap_hit)
                    next_state = TRAP_SVC;
                else
                    next_state = FS_IF0;
            end
            WB_0: begin
                if (opcode[5:3] == 3'b000) begin
                    cmd[DSTREG] = 1'b1;
                    cmd[SETREG] = 1'b1;
                    next_state  = FS_IF0;
                end else if (bus_err) begin
                    cmd[BUSERR] = 1'b1;
                    next_state  = TRAP_SVC;
                end else if (bus_done) begin
                    next_state = FS_IF0;
                end else begin
                    wr_req      = 1'b1;
                    byte_req    = opcode[15];
                    cmd[DBODST] = 1'b1;
                    cmd[DBAADR] = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- fetch_decode.sv
/*
 * Boot step, instruction fetch with PC increment, and dispatch on the
 * predecoded instruction class.
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_decode (
    input  lsi_control_pkg::ctl_state_t   state,
    input  lsi_control_pkg::opnd_side_t   side,
    input  logic                          bus_done,
    input  logic                          bus_err,
    input  logic                          idc_unused,
    input  logic                          idc_nof,
    input  logic                          idc_sop,
    input  logic                          idc_dop,
    output logic                          owns,
    output lsi_control_pkg::ctl_state_t   next_state,
    output lsi_control_pkg::dp_cmd_t      cmd,
    output logic                          rd_req,
    output logic                          wr_req,
    output logic                          byte_req,
    output logic                          fetch_req,
    output logic                          side_chg,
    output lsi_control_pkg::opnd_side_t   side_val
);
    import lsi_control_pkg::*;

    assign owns = state inside {BOOT_0, FS_IF0, FS_ID0};

    always_comb begin
        cmd        = '0;
        next_state = state;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        byte_req   = 1'b0;
        fetch_req  = 1'b0;
        side_chg   = 1'b0;
        side_val   = side;
        case (state)
            BOOT_0: begin
                cmd[SETPCROM] = 1'b1;
                next_state    = FS_IF0;
            end
            FS_IF0: begin
                if (bus_err) begin
                    cmd[BUSERR] = 1'b1;
                    next_state  = TRAP_SVC;
                end else if (bus_done) begin
                    // opcode latched, step PC past it
                    cmd[PCALU1] = 1'b1;
                    cmd[INC2]   = 1'b1;
                    cmd[ALUPC]  = 1'b1;
                    cmd[SETOPC] = 1'b1;
                    next_state  = FS_ID0;
                end else begin
                    rd_req     = 1'b1;
                    fetch_req  = 1'b1;
                    cmd[DBAPC] = 1'b1;
                end
            end
            FS_ID0: begin
                side_chg = idc_sop | idc_dop;
                if (idc_nof & ~idc_unused) begin
                    next_state = EX_0;
                end else if (idc_sop & ~idc_unused) begin
                    cmd[CHANGE_OPR] = 1'b1;
                    side_val        = SRC_OP;
                    next_state      = FS_OF1;
                end else if (idc_dop & ~idc_unused) begin
                    side_val   = DST_OP;
                    next_state = FS_OF1;
                end else begin
                    // unused opcode, or no class at all
                    side_chg   = 1'b0;
                    cmd[ERR]   = 1'b1;
                    next_state = TRAP_SVC;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- lsi_control.f
lsi_control_pkg.sv
ctl_sequencer.sv
fetch_decode.sv
operand_fetch.sv
execute_writeback.sv
trap_sequencer.sv
lsi_control.sv
tb_lsi_control.sv

//--- lsi_control.sv
/*
 * Control sequencer top level. Connects the state register to the
 * fetch/decode, operand fetch, execute/writeback and trap decoders.
 */
`timescale 1ns/10ps
`default_nettype none

module lsi_control (
    input  logic                       clk,
    input  logic                       reset_n,
    input  lsi_control_pkg::word_t     opcode,
    input  logic                       idc_unused,
    input  logic                       idc_nof,
    input  logic                       idc_sop,
    input  logic                       idc_dop,
    input  lsi_control_pkg::idc_op_t   idc_op,
    input  logic                       ready,
    input  logic                       ierror,
    output lsi_control_pkg::dp_cmd_t   dp_cmd,
    output logic                       dati,
    output logic                       dato,
    output logic                       mbyte,
    output logic                       ifetch
);
    import lsi_control_pkg::*;

    ctl_state_t state, fd_next_state, of_next_state, ex_next_state, tr_next_state;
    opnd_side_t side, fd_side_val, of_side_val, ex_side_val, tr_side_val;
    dp_cmd_t    fd_cmd, of_cmd, ex_cmd, tr_cmd;
    logic       bus_done, bus_err;
    logic       fd_owns, of_owns, ex_owns, tr_owns;
    logic       fd_rd_req, of_rd_req, ex_rd_req, tr_rd_req;
    logic       fd_wr_req, of_wr_req, ex_wr_req, tr_wr_req;
    logic       fd_byte_req, of_byte_req, ex_byte_req, tr_byte_req;
    logic       fd_fetch_req, of_fetch_req, ex_fetch_req, tr_fetch_req;
    logic       fd_side_chg, of_side_chg, ex_side_chg, tr_side_chg;

    ctl_sequencer u_seq (.*);

    fetch_decode u_fd (
        .state(state), .side(side), .bus_done(bus_done), .bus_err(bus_err),
        .idc_unused(idc_unused), .idc_nof(idc_nof), .idc_sop(idc_sop), .idc_dop(idc_dop),
        .owns(fd_owns), .next_state(fd_next_state), .cmd(fd_cmd),
        .rd_req(fd_rd_req), .wr_req(fd_wr_req), .byte_req(fd_byte_req),
        .fetch_req(fd_fetch_req), .side_chg(fd_side_chg), .side_val(fd_side_val)
    );

    operand_fetch u_of (
        .state(state), .side(side), .opcode(opcode), .bus_done(bus_done), .bus_err(bus_err),
        .owns(of_owns), .next_state(of_next_state), .cmd(of_cmd),
        .rd_req(of_rd_req), .wr_req(of_wr_req), .byte_req(of_byte_req),
        .fetch_req(of_fetch_req), .side_chg(of_side_chg), .side_val(of_side_val)
    );

    execute_writeback u_ex (
        .state(state), .opcode(opcode), .idc_op(idc_op), .bus_done(bus_done),
        .bus_err(bus_err),
        .owns(ex_owns), .next_state(ex_next_state), .cmd(ex_cmd),
        .rd_req(ex_rd_req), .wr_req(ex_wr_req), .byte_req(ex_byte_req),
        .fetch_req(ex_fetch_req), .side_chg(ex_side_chg), .side_val(ex_side_val)
    );

    trap_sequencer u_tr (
        .state(state), .bus_done(bus_done), .bus_err(bus_err),
        .owns(tr_owns), .next_state(tr_next_state), .cmd(tr_cmd),
        .rd_req(tr_rd_req), .wr_req(tr_wr_req), .byte_req(tr_byte_req),
        .fetch_req(tr_fetch_req), .side_chg(tr_side_chg), .side_val(tr_side_val)
    );

endmodule

`default_nettype wire

//--- lsi_control_pkg.sv
/*
 * Shared definitions for the LSI-11 control sequencer: state codes,
 * datapath command bit indices and one-hot operation indices.
 */
`default_nettype none

package lsi_control_pkg;

    localparam int WORD_W  = 16;
    localparam int STATE_W = 6;

    typedef logic [WORD_W-1:0] word_t;

    // ==============================
    // sequencer states
    // ==============================
    typedef enum logic [STATE_W-1:0] {
        BOOT_0   = 6'd0,
        FS_IF0   = 6'd1,
        FS_ID0   = 6'd3,
        FS_OF1   = 6'd6,
        FS_OF3   = 6'd8,
        FS_OF4   = 6'd9,
        EX_0     = 6'd16,
        WB_0     = 6'd32,
        TRAP_1   = 6'd49,
        TRAP_2   = 6'd50,
        TRAP_3   = 6'd51,
        TRAP_4   = 6'd52,
        TRAP_SVC = 6'd56
    } ctl_state_t;

    // ==============================
    // datapath command bits
    // ==============================
    typedef enum int {
        SETPCROM, PCALU1, ALUPC, SETOPC, DBAPC, ADRPC,
        REGSEL, SELSRC, SELDST, SELALU1, ALUREG, SETREG, CHANGE_OPR, RESET_BYTE,
        INC, INC2, DEC, DEC2, CLR, COM, NEG, TST, MOV, CMP, BIT, BIC, BIS, ADD,
        ALUSRC, ALUDST, ALUDSTB, ALUCC, DBISRC, DBIDST, SRCADR, DSTADR,
        DBASRC, DBADST, SRCALU1, DSTALU1, DSTALU2,
        DSTREG, DBODST, DBAADR,
        BUSERR, ERR, BPT, IOT, EMT, SVC, SAVE_STAT, DBIPC, VECTORPS,
        SPALU1, ALUSP, DBASP, DBOADR
    } dp_cmd_e;

    localparam int DP_CMD_W = 57;

    typedef logic [DP_CMD_W-1:0] dp_cmd_t;

    // one-hot operations from the predecoder
    typedef enum int {
        dclr, dcom, dinc, ddec, dneg, dtst,
        dmov, dcmp, dbit, dbic, dbis, dadd,
        dnop, dbpt, diot, demt, dtrap, dhalt
    } idc_op_e;

    localparam int IDC_OP_W = 18;

    typedef logic [IDC_OP_W-1:0] idc_op_t;

    // which operand the fetch states are working on
    typedef logic opnd_side_t;

    localparam opnd_side_t SRC_OP = 1'b0;
    localparam opnd_side_t DST_OP = 1'b1;

endpackage

`default_nettype wire

//--- operand_fetch.sv
/*
 * Operand fetch for register, autoincrement, autodecrement and the
 * deferred forms of each. Handles source then destination.
 */
`timescale 1ns/10ps
`default_nettype none

module operand_fetch (
    input  lsi_control_pkg::ctl_state_t   state,
    input  lsi_control_pkg::opnd_side_t   side,
    input  lsi_control_pkg::word_t        opcode,
    input  logic                          bus_done,
    input  logic                          bus_err,
    output logic                          owns,
    output lsi_control_pkg::ctl_state_t   next_state,
    output lsi_control_pkg::dp_cmd_t      cmd,
    output logic                          rd_req,
    output logic                          wr_req,
    output logic                          byte_req,
    output logic                          fetch_req,
    output logic                          side_chg,
    output lsi_control_pkg::opnd_side_t   side_val
);
    import lsi_control_pkg::*;

    logic [1:0] mode;
    logic       indr, sppc, byte_op, byte_step, is_dst, addr_read;

    assign mode      = opcode[5:4];
    assign indr      = opcode[3];
    assign sppc      = opcode[2] & opcode[1];
    assign byte_op   = opcode[15];
    // SP and PC always step by two, as do pointers
    assign byte_step = byte_op & ~(indr | sppc);
    assign is_dst    = (side == DST_OP);
    // deferred first read fetches a pointer, not the operand
    assign addr_read = (state == FS_OF3) & indr;

    assign owns = state inside {FS_OF1, FS_OF3, FS_OF4};

    always_comb begin
        cmd        = '0;
        next_state = state;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        byte_req   = 1'b0;
        fetch_req  = 1'b0;
        side_chg   = 1'b0;
        side_val   = DST_OP;
        case (state)
            FS_OF1: begin
                cmd[REGSEL] = (mode != 2'b11);
                if (mode == 2'b00) begin
                    cmd[SELSRC] = ~is_dst;
                    cmd[SELDST] = is_dst;
                    if (indr)
                        next_state = FS_OF4;
                    else if (is_dst)
                        next_state = EX_0;
                    else begin
                        cmd[CHANGE_OPR] = 1'b1;
                        side_chg        = 1'b1;
                    end
                end else if (mode != 2'b11) begin
                    cmd[SELALU1] = 1'b1;
                    cmd[ALUREG]  = 1'b1;
                    cmd[SETREG]  = 1'b1;
                    cmd[INC]     = mode[0] & byte_step;
                    cmd[INC2]    = mode[0] & ~byte_step;
                    cmd[DEC]     = mode[1] & byte_step;
                    cmd[DEC2]    = mode[1] & ~byte_step;
                    // autoinc addresses the old value, autodec the new one
                    cmd[SELSRC]  = mode[0] & ~is_dst;
                    cmd[SELDST]  = mode[0] & is_dst;
                    cmd[ALUSRC]  = mode[1] & ~is_dst;
                    cmd[ALUDST]  = mode[1] & is_dst;
                    next_state   = FS_OF3;
                end else begin
                    // index mode not supported
                    cmd[ERR]   = 1'b1;
                    next_state = TRAP_SVC;
                end
            end
            FS_OF3, FS_OF4: begin
                if (bus_err) begin
                    cmd[BUSERR] = 1'b1;
                    next_state  = TRAP_SVC;
                end else if (bus_done) begin
                    cmd[DBIDST] = is_dst;
                    cmd[DSTADR] = is_dst;
                    cmd[DBISRC] = ~is_dst;
                    cmd[SRCADR] = ~is_dst;
                    if (addr_read)
                        next_state = FS_OF4;
                    else if (is_dst)
                        next_state = EX_0;
                    else begin
                        cmd[CHANGE_OPR] = 1'b1;
                        side_chg        = 1'b1;
                        next_state      = FS_OF1;
                    end
                end else begin
                    rd_req      = 1'b1;
                    byte_req    = byte_op & ~addr_read;
                    cmd[DBASRC] = ~is_dst;
                    cmd[DBADST] = is_dst;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- tb_lsi_control.sv
/*
 * Directed testbench for the control sequencer. A small bus responder
 * answers each strobe; every test task drives one instruction through.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_lsi_control;
    import lsi_control_pkg::*;

    localparam int TIMEOUT = 50;

    logic     clk;
    logic     reset_n;
    word_t    opcode;
    logic     idc_unused, idc_nof, idc_sop, idc_dop;
    idc_op_t  idc_op;
    logic     ready, ierror;
    dp_cmd_t  dp_cmd;
    logic     dati, dato, mbyte, ifetch;

    integer   seed;

    lsi_control uut (
        .clk(clk), .reset_n(reset_n), .opcode(opcode),
        .idc_unused(idc_unused), .idc_nof(idc_nof), .idc_sop(idc_sop), .idc_dop(idc_dop),
        .idc_op(idc_op), .ready(ready), .ierror(ierror),
        .dp_cmd(dp_cmd), .dati(dati), .dato(dato), .mbyte(mbyte), .ifetch(ifetch)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic dp_cmd_t cmd1(input dp_cmd_e b);
        dp_cmd_t c;
        c    = '0;
        c[b] = 1'b1;
        return c;
    endfunction

    function automatic idc_op_t op1(input idc_op_e o);
        idc_op_t v;
        v    = '0;
        v[o] = 1'b1;
        return v;
    endfunction

    task automatic abort_run;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_cmd(input string name, input dp_cmd_t exp, input dp_cmd_t got);
        if (exp !== got) begin
            $display("Mismatch %s exp=%h got=%h", name, exp, got);
            abort_run();
        end
    endtask

    // strobes packed as {dati, dato, ifetch}
    task automatic check_strobes(input logic [2:0] exp, input logic [2:0] got);
        if (exp !== got) begin
            $display("Mismatch strobes{dati,dato,ifetch} exp=%h got=%h", exp, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("Mismatch %s exp=%h got=%h", name, exp, got);
            abort_run();
        end
    endtask

    // outputs are sampled on the falling edge
    task automatic next_cycle;
        @(negedge clk);
    endtask

    task automatic wait_strobe(input string what);
        int cycles;
        cycles = 0;
        while (!(dati | dato)) begin
            next_cycle();
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for a bus strobe for %s", what);
                abort_run();
            end
        end
    endtask

    task automatic wait_cmd_bit(input dp_cmd_e b, input string what);
        int cycles;
        cycles = 0;
        while (dp_cmd[b] !== 1'b1) begin
            next_cycle();
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for the %s command word", what);
                abort_run();
            end
        end
    endtask

    // answer the pending strobe one cycle later; returns on the completion word
    task automatic answer_bus(input logic with_error);
        @(posedge clk);
        if (with_error)
            ierror <= 1'b1;
        else
            ready <= 1'b1;
        next_cycle();
        @(posedge clk);
        ready  <= 1'b0;
        ierror <= 1'b0;
        next_cycle();
    endtask

    task automatic load_instr(input word_t op, input logic unused, input logic nof,
                              input logic sop, input logic dop, input idc_op_t ops);
        @(posedge clk);
        opcode     <= op;
        idc_unused <= unused;
        idc_nof    <= nof;
        idc_sop    <= sop;
        idc_dop    <= dop;
        idc_op     <= ops;
        next_cycle();
    endtask

    task automatic check_fetch_read;
        check_strobes(3'b101, {dati, dato, ifetch});
        check_flag("mbyte", 1'b0, mbyte);
        check_cmd("dp_cmd", cmd1(DBAPC), dp_cmd);
    endtask

    // save status, two vector reads, two pushes, then a new fetch
    task automatic trap_entry_checks;
        next_cycle();
        check_cmd("dp_cmd", cmd1(RESET_BYTE) | cmd1(SAVE_STAT), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        wait_strobe("vector pc read");
        check_strobes(3'b100, {dati, dato, ifetch});
        check_cmd("dp_cmd", cmd1(DBASRC), dp_cmd);
        answer_bus(1'b0);
        check_cmd("dp_cmd", cmd1(DBIPC) | cmd1(SRCALU1) | cmd1(INC2) | cmd1(ALUSRC), dp_cmd);
        wait_strobe("vector ps read");
        check_strobes(3'b100, {dati, dato, ifetch});
        answer_bus(1'b0);
        check_cmd("dp_cmd", cmd1(VECTORPS) | cmd1(SPALU1) | cmd1(DEC2) | cmd1(ALUSP), dp_cmd);
        wait_strobe("status push");
        check_strobes(3'b010, {dati, dato, ifetch});
        check_flag("mbyte", 1'b0, mbyte);
        check_cmd("dp_cmd", cmd1(DBODST) | cmd1(DBASP), dp_cmd);
        answer_bus(1'b0);
        check_cmd("dp_cmd", cmd1(SPALU1) | cmd1(DEC2) | cmd1(ALUSP), dp_cmd);
        wait_strobe("pc push");
        check_strobes(3'b010, {dati, dato, ifetch});
        check_cmd("dp_cmd", cmd1(DBOADR) | cmd1(DBASP), dp_cmd);
        answer_bus(1'b0);
        wait_strobe("fetch after trap");
        check_fetch_read();
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic test_reset_boot;
        repeat (2) @(posedge clk);
        next_cycle();
        check_cmd("dp_cmd", '0, dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        check_flag("mbyte", 1'b0, mbyte);
        @(posedge clk);
        reset_n <= 1'b1;
        next_cycle();
        next_cycle();
        check_cmd("dp_cmd", cmd1(SETPCROM), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        next_cycle();
        check_fetch_read();
    endtask

    task automatic test_fetch_done(input word_t op, input logic sop, input idc_op_t ops);
        load_instr(op, 1'b0, 1'b0, sop, ~sop, ops);
        answer_bus(1'b0);
        check_cmd("dp_cmd", cmd1(PCALU1) | cmd1(INC2) | cmd1(ALUPC) | cmd1(SETOPC), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
    endtask

    task automatic test_sop_register;
        // inc r1
        test_fetch_done(16'h0A81, 1'b1, op1(dinc));
        wait_cmd_bit(ALUCC, "execute");
        check_cmd("dp_cmd", cmd1(DSTALU1) | cmd1(INC) | cmd1(ALUDSTB) | cmd1(ALUCC), dp_cmd);
        next_cycle();
        check_cmd("dp_cmd", cmd1(DSTREG) | cmd1(SETREG), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        next_cycle();
        check_fetch_read();
    endtask

    task automatic test_dop_autoinc_byte;
        // movb with autoincrement fields
        test_fetch_done(16'h9411, 1'b0, op1(dmov));
        wait_cmd_bit(ALUREG, "register step");
        check_flag("dp_cmd[INC]", 1'b1, dp_cmd[INC]);
        check_flag("dp_cmd[INC2]", 1'b0, dp_cmd[INC2]);
        wait_strobe("operand read");
        check_strobes(3'b100, {dati, dato, ifetch});
        check_flag("mbyte", 1'b1, mbyte);
        answer_bus(1'b0);
        // byte flag holds once the strobe drops
        check_flag("mbyte", 1'b1, mbyte);
        wait_cmd_bit(ALUCC, "execute");
        check_flag("dp_cmd[MOV]", 1'b1, dp_cmd[MOV]);
        wait_strobe("result write");
        check_strobes(3'b010, {dati, dato, ifetch});
        check_flag("mbyte", 1'b1, mbyte);
        check_cmd("dp_cmd", cmd1(DBODST) | cmd1(DBAADR), dp_cmd);
        answer_bus(1'b0);
        wait_strobe("next fetch");
        check_fetch_read();
    endtask

    task automatic test_bus_error_trap;
        // operand read of inc (r1)+ faults
        test_fetch_done(16'h0A91, 1'b1, op1(dinc));
        wait_strobe("operand read");
        check_strobes(3'b100, {dati, dato, ifetch});
        answer_bus(1'b1);
        check_cmd("dp_cmd", cmd1(BUSERR), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        trap_entry_checks();
    endtask

    task automatic test_unused_trap;
        // unused outranks the nop class raised with it
        load_instr(16'h0007, 1'b1, 1'b1, 1'b0, 1'b0, op1(dnop));
        answer_bus(1'b0);
        next_cycle();
        check_cmd("dp_cmd", cmd1(ERR), dp_cmd);
        check_strobes(3'b000, {dati, dato, ifetch});
        trap_entry_checks();
    endtask

    task automatic test_back_pressure;
        int hold;
        hold = 1 + ($unsigned($random(seed)) % 8);
        load_instr(16'h00A0, 1'b0, 1'b1, 1'b0, 1'b0, op1(dnop));
        repeat (hold) begin
            next_cycle();
            check_fetch_read();
        end
        answer_bus(1'b0);
        check_cmd("dp_cmd", cmd1(PCALU1) | cmd1(INC2) | cmd1(ALUPC) | cmd1(SETOPC), dp_cmd);
        next_cycle();
        check_cmd("dp_cmd", '0, dp_cmd);
        wait_strobe("fetch after nop");
        check_fetch_read();
    endtask

    initial begin
        seed        = 32'h9c0f_6257;
        reset_n     = 1'b0;
        opcode      = '0;
        idc_unused  = 1'b0;
        idc_nof     = 1'b0;
        idc_sop     = 1'b0;
        idc_dop     = 1'b0;
        idc_op      = '0;
        ready       = 1'b0;
        ierror      = 1'b0;

        test_reset_boot();
        test_sop_register();
        test_dop_autoinc_byte();
        test_bus_error_trap();
        test_unused_trap();
        test_back_pressure();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- trap_sequencer.sv
/*
 * Trap entry: save status, read the new PC and PS from the vector,
 * then push the old PS and PC onto the stack.
 */
`timescale 1ns/10ps
`default_nettype none

module trap_sequencer (
    input  lsi_control_pkg::ctl_state_t   state,
    input  logic                          bus_done,
    input  logic                          bus_err,
    output logic                          owns,
    output lsi_control_pkg::ctl_state_t   next_state,
    output lsi_control_pkg::dp_cmd_t      cmd,
    output logic                          rd_req,
    output logic                          wr_req,
    output logic                          byte_req,
    output logic                          fetch_req,
    output logic                          side_chg,
    output lsi_control_pkg::opnd_side_t   side_val
);
    import lsi_control_pkg::*;

    logic vec_read;

    assign owns     = state inside {TRAP_SVC, TRAP_1, TRAP_2, TRAP_3, TRAP_4};
    // first two steps read the vector, last two push
    assign vec_read = (state == TRAP_1) | (state == TRAP_2);

    always_comb begin
        cmd        = '0;
        next_state = state;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        byte_req   = 1'b0;
        fetch_req  = 1'b0;
        side_chg   = 1'b0;
        side_val   = SRC_OP;
        if (state == TRAP_SVC) begin
            cmd[RESET_BYTE] = 1'b1;
            cmd[SAVE_STAT]  = 1'b1;
            next_state      = TRAP_1;
        end else if (owns & bus_err) begin
            // fault inside the sequence starts it over
            cmd[BUSERR] = 1'b1;
            next_state  = TRAP_SVC;
        end else if (owns & bus_done) begin
            case (state)
                TRAP_1: begin
                    cmd[DBIPC]   = 1'b1;
                    cmd[SRCALU1] = 1'b1;
                    cmd[INC2]    = 1'b1;
                    cmd[ALUSRC]  = 1'b1;
                    next_state   = TRAP_2;
                end
                TRAP_2, TRAP_3: begin
                    cmd[VECTORPS] = (state == TRAP_2);
                    cmd[SPALU1]   = 1'b1;
                    cmd[DEC2]     = 1'b1;
                    cmd[ALUSP]    = 1'b1;
                    next_state    = (state == TRAP_2) ? TRAP_3 : TRAP_4;
                end
                default: next_state = FS_IF0;
            endcase
        end else if (owns) begin
            rd_req      = vec_read;
            wr_req      = ~vec_read;
            cmd[DBASRC] = vec_read;
            cmd[DBODST] = (state == TRAP_3);
            cmd[DBOADR] = (state == TRAP_4);
            cmd[DBASP]  = ~vec_read;
        end
    end

endmodule

`default_nettype wire
